//--- logic/cpu_types_pkg.sv
package cpu_types_pkg;

    // datapath widths
    typedef logic [15:0] word_t;     // one bus word
    typedef logic [7:0]  addr_t;     // RAM address, taken from bus[7:0]
    typedef logic [7:0]  opcode_t;   // IR high byte
    typedef logic [2:0]  tstate_t;   // microstep counter
    typedef logic        flag_t;     // single ALU flag

    localparam int MEM_WORDS = 256;

    // the sequencer parks here when no step ends the instruction
    localparam tstate_t T_LAST = 3'd7;

    // instruction set, low byte of the instruction is the operand
    localparam opcode_t OP_LDX_IMM = 8'h01;  // x = operand
    localparam opcode_t OP_LDY_IMM = 8'h02;  // y = operand
    localparam opcode_t OP_LDX_MEM = 8'h03;  // x = mem[operand]
    localparam opcode_t OP_STX     = 8'h04;  // mem[operand] = x

    localparam opcode_t OP_ADD     = 8'h10;  // x = x op y
    localparam opcode_t OP_SUB     = 8'h11;
    localparam opcode_t OP_AND     = 8'h12;
    localparam opcode_t OP_OR      = 8'h13;
    localparam opcode_t OP_XOR     = 8'h14;

    localparam opcode_t OP_OUT     = 8'h20;  // device port gets x
    localparam opcode_t OP_IN      = 8'h21;  // x = device input

    localparam opcode_t OP_JMP     = 8'h30;  // pc = operand
    localparam opcode_t OP_JZ      = 8'h31;
    localparam opcode_t OP_JLT     = 8'h32;
    localparam opcode_t OP_JGT     = 8'h33;

    // stops fetching, the sequencer idles until reset
    localparam opcode_t OP_HALT    = 8'hff;

endpackage

//--- logic/ucode_pkg.sv
package ucode_pkg;

    typedef logic [15:0] uinstr_t;
    typedef logic [2:0]  bus_src_t;
    typedef logic [2:0]  bus_dst_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [2:0]  jump_t;     // {jz, jgt, jlt}

    // microinstruction layout
    localparam int EO_BIT  = 15;     // bus output enable, active low
    localparam int SRC_LSB = 12;     // bus-out field [14:12]
    localparam int RT_BIT  = 11;     // end of instruction
    localparam int PP_BIT  = 10;     // pc increment
    localparam int ALU_LSB = 7;      // alu operation [9:7]
    localparam int DST_LSB = 4;      // bus-in field [6:4]
    localparam int JZ_BIT  = 3;
    localparam int JGT_BIT = 2;
    localparam int JLT_BIT = 1;

    // bus-out codes
    localparam bus_src_t SRC_PC  = 3'd0;
    localparam bus_src_t SRC_IRH = 3'd1;   // ones over the operand
    localparam bus_src_t SRC_IRL = 3'd2;   // zeros over the operand
    localparam bus_src_t SRC_MEM = 3'd3;
    localparam bus_src_t SRC_ALU = 3'd4;
    localparam bus_src_t SRC_DEV = 3'd6;

    // bus-in codes, 0 means nobody takes the bus
    localparam bus_dst_t DST_NONE = 3'd0;
    localparam bus_dst_t DST_AR   = 3'd1;
    localparam bus_dst_t DST_IR   = 3'd2;
    localparam bus_dst_t DST_MEM  = 3'd3;
    localparam bus_dst_t DST_X    = 3'd4;
    localparam bus_dst_t DST_Y    = 3'd5;
    localparam bus_dst_t DST_DEV  = 3'd6;

    localparam alu_op_t ALU_X   = 3'd0;    // pass x through
    localparam alu_op_t ALU_ADD = 3'd1;
    localparam alu_op_t ALU_SUB = 3'd2;
    localparam alu_op_t ALU_AND = 3'd3;
    localparam alu_op_t ALU_OR  = 3'd4;
    localparam alu_op_t ALU_XOR = 3'd5;

    localparam jump_t JMP_NONE   = 3'b000;
    localparam jump_t JMP_Z      = 3'b100;
    localparam jump_t JMP_GT     = 3'b010;
    localparam jump_t JMP_LT     = 3'b001;
    localparam jump_t JMP_ALWAYS = 3'b111;   // one of the three always holds

    // bus off, no destination, no rt
    localparam uinstr_t U_IDLE = 16'h8000;

endpackage

//--- logic/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom (
    input  cpu_types_pkg::opcode_t opcode,
    input  cpu_types_pkg::tstate_t t,
    output ucode_pkg::uinstr_t     uinstr
);
    import cpu_types_pkg::*;
    import ucode_pkg::*;

    // one bus transfer with the bus enabled
    function automatic uinstr_t step(
        input bus_src_t src,
        input bus_dst_t dst,
        input alu_op_t  op,
        input logic     rt,
        input logic     pp,
        input jump_t    jmp
    );
        uinstr_t u;
        u = '0;
        u[EO_BIT]        = 1'b0;
        u[SRC_LSB +: 3]  = src;
        u[RT_BIT]        = rt;
        u[PP_BIT]        = pp;
        u[ALU_LSB +: 3]  = op;
        u[DST_LSB +: 3]  = dst;
        u[JZ_BIT]        = jmp[2];
        u[JGT_BIT]       = jmp[1];
        u[JLT_BIT]       = jmp[0];
        return u;
    endfunction

    always_comb begin
        uinstr = U_IDLE;
        case (t)
            // fetch, IR still holds the previous instruction here
            3'd0: uinstr = step(SRC_PC, DST_AR, ALU_X, 1'b0, 1'b0, JMP_NONE);
            3'd1: uinstr = step(SRC_MEM, DST_IR, ALU_X, 1'b0, 1'b1, JMP_NONE);

            3'd2: begin
                case (opcode)
                    OP_LDX_IMM: uinstr = step(SRC_IRL, DST_X, ALU_X, 1'b1, 1'b0, JMP_NONE);
                    OP_LDY_IMM: uinstr = step(SRC_IRL, DST_Y, ALU_X, 1'b1, 1'b0, JMP_NONE);
                    OP_LDX_MEM: uinstr = step(SRC_IRL, DST_AR, ALU_X, 1'b0, 1'b0, JMP_NONE);
                    OP_STX:     uinstr = step(SRC_IRL, DST_AR, ALU_X, 1'b0, 1'b0, JMP_NONE);
                    OP_ADD:     uinstr = step(SRC_ALU, DST_X, ALU_ADD, 1'b1, 1'b0, JMP_NONE);
                    OP_SUB:     uinstr = step(SRC_ALU, DST_X, ALU_SUB, 1'b1, 1'b0, JMP_NONE);
                    OP_AND:     uinstr = step(SRC_ALU, DST_X, ALU_AND, 1'b1, 1'b0, JMP_NONE);
                    OP_OR:      uinstr = step(SRC_ALU, DST_X, ALU_OR, 1'b1, 1'b0, JMP_NONE);
                    OP_XOR:     uinstr = step(SRC_ALU, DST_X, ALU_XOR, 1'b1, 1'b0, JMP_NONE);
                    OP_OUT:     uinstr = step(SRC_ALU, DST_DEV, ALU_X, 1'b1, 1'b0, JMP_NONE);
                    OP_IN:      uinstr = step(SRC_DEV, DST_X, ALU_X, 1'b1, 1'b0, JMP_NONE);
                    // operand on the bus, the jump logic picks it up
                    OP_JMP:     uinstr = step(SRC_IRL, DST_NONE, ALU_X, 1'b1, 1'b0, JMP_ALWAYS);
                    OP_JZ:      uinstr = step(SRC_IRL, DST_NONE, ALU_X, 1'b1, 1'b0, JMP_Z);
                    OP_JLT:     uinstr = step(SRC_IRL, DST_NONE, ALU_X, 1'b1, 1'b0, JMP_LT);
                    OP_JGT:     uinstr = step(SRC_IRL, DST_NONE, ALU_X, 1'b1, 1'b0, JMP_GT);
                    default:    uinstr = U_IDLE;   // halt and anything unknown
                endcase
            end

            3'd3: begin
                case (opcode)
                    OP_LDX_MEM: uinstr = step(SRC_MEM, DST_X, ALU_X, 1'b1, 1'b0, JMP_NONE);
                    OP_STX:     uinstr = step(SRC_ALU, DST_MEM, ALU_X, 1'b1, 1'b0, JMP_NONE);
                    default:    uinstr = U_IDLE;
                endcase
            end

            default: uinstr = U_IDLE;
        endcase
    end

endmodule

//--- logic/instruction_card.sv
`timescale 1ns/1ps

module instruction_card (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_types_pkg::word_t   bus,
    input  logic                   z,
    input  logic                   lt,
    output ucode_pkg::bus_src_t    bus_src,
    output logic                   eo_n,
    output logic                   ai,
    output logic                   mi,
    output logic                   xi,
    output logic                   yi,
    output logic                   di,
    output ucode_pkg::alu_op_t     alu_op,
    output cpu_types_pkg::word_t   pc,
    output cpu_types_pkg::word_t   ir
);
    import cpu_types_pkg::*;
    import ucode_pkg::*;

    tstate_t  t;
    uinstr_t  uinstr;
    bus_dst_t bus_dst;
    logic     ii;
    logic     pp;
    logic     rt;
    logic     jz;
    logic     jgt;
    logic     jlt;
    logic     jmp;

    // microcode is addressed by opcode and T-state
    ucode_rom rom_i (
        .opcode (ir[15:8]),
        .t      (t),
        .uinstr (uinstr)
    );

    // control decode
    assign eo_n    = uinstr[EO_BIT];
    assign bus_src = uinstr[SRC_LSB +: 3];
    assign alu_op  = uinstr[ALU_LSB +: 3];   // operation behind the alu result
    assign bus_dst = uinstr[DST_LSB +: 3];
    assign rt      = uinstr[RT_BIT];
    assign pp      = uinstr[PP_BIT];
    assign jz      = uinstr[JZ_BIT];
    assign jgt     = uinstr[JGT_BIT];
    assign jlt     = uinstr[JLT_BIT];

    // one strobe per bus-in code
    always_comb begin
        ai = 1'b0;
        ii = 1'b0;
        mi = 1'b0;
        xi = 1'b0;
        yi = 1'b0;
        di = 1'b0;
        case (bus_dst)
            DST_AR:  ai = 1'b1;
            DST_IR:  ii = 1'b1;
            DST_MEM: mi = 1'b1;
            DST_X:   xi = 1'b1;
            DST_Y:   yi = 1'b1;
            DST_DEV: di = 1'b1;
            default: ;             // DST_NONE has no listener
        endcase
    end

    // gt is neither zero nor negative
    assign jmp = (jz & z) | (jlt & lt) | (jgt & ~z & ~lt);

    // T-state sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t <= '0;
        end else if (rt) begin
            t <= '0;
        end else if (t != T_LAST) begin
            t <= t + 3'd1;   // halt never asserts rt and parks at T_LAST
        end
    end

    // program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (jmp) begin
            pc <= bus;           // taken jump wins over increment
        end else if (pp) begin
            pc <= pc + 16'd1;
        end
    end

    // instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ii) begin
            ir <= bus;
        end
    end

endmodule

//--- logic/alu_card.sv
`timescale 1ns/1ps

module alu_card (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_types_pkg::word_t bus,
    input  logic                 xi,
    input  logic                 yi,
    input  ucode_pkg::alu_op_t   alu_op,
    output cpu_types_pkg::word_t result,
    output logic                 z,
    output logic                 lt
);
    import cpu_types_pkg::*;
    import ucode_pkg::*;

    word_t x;
    word_t y;
    flag_t z_next;
    flag_t lt_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
        end else if (xi) begin
            x <= bus;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else if (yi) begin
            y <= bus;
        end
    end

    always_comb begin
        case (alu_op)
            ALU_X:   result = x;
            ALU_ADD: result = x + y;   // no carry out
            ALU_SUB: result = x - y;
            ALU_AND: result = x & y;
            ALU_OR:  result = x | y;
            ALU_XOR: result = x ^ y;
            default: result = x;
        endcase
    end

    // flags follow the value going into x
    assign z_next  = (bus == '0);
    assign lt_next = bus[15];   // signed compare against zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            z  <= 1'b0;
            lt <= 1'b0;
        end else if (xi) begin
            z  <= z_next;
            lt <= lt_next;
        end
    end

endmodule

//--- logic/memory_card.sv
`timescale 1ns/1ps

module memory_card (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_types_pkg::word_t bus,
    input  logic                 ai,
    input  logic                 mi,
    input  logic                 load_valid,
    input  cpu_types_pkg::addr_t load_addr,
    input  cpu_types_pkg::word_t load_data,
    output cpu_types_pkg::word_t rdata
);
    import cpu_types_pkg::*;

    addr_t ar;
    word_t ram [MEM_WORDS];

    // address register, low byte of the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar <= '0;
        end else if (ai) begin
            ar <= bus[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if (load_valid) begin
                ram[load_addr] <= load_data;   // program load, cpu held in reset
            end
        end else if (mi) begin
            ram[ar] <= bus;
        end
    end

    assign rdata = ram[ar];   // async read

endmodule

//--- logic/scamp_cpu.sv
`timescale 1ns/1ps

module scamp_cpu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_valid,
    input  cpu_types_pkg::addr_t load_addr,
    input  cpu_types_pkg::word_t load_data,
    input  cpu_types_pkg::word_t dev_in_data,
    output logic                 dev_out_valid,
    output cpu_types_pkg::word_t dev_out_data,
    output logic                 halted
);
    import cpu_types_pkg::*;
    import ucode_pkg::*;

    word_t    bus;
    word_t    pc;
    word_t    ir;
    word_t    alu_result;
    word_t    mem_rdata;
    bus_src_t bus_src;
    alu_op_t  alu_op;
    logic     eo_n;
    logic     ai;
    logic     mi;
    logic     xi;
    logic     yi;
    logic     di;
    logic     z;
    logic     lt;

    instruction_card instr_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus),
        .z       (z),
        .lt      (lt),
        .bus_src (bus_src),
        .eo_n    (eo_n),
        .ai      (ai),
        .mi      (mi),
        .xi      (xi),
        .yi      (yi),
        .di      (di),
        .alu_op  (alu_op),
        .pc      (pc),
        .ir      (ir)
    );

    alu_card alu_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .xi     (xi),
        .yi     (yi),
        .alu_op (alu_op),
        .result (alu_result),
        .z      (z),
        .lt     (lt)
    );

    memory_card mem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .ai         (ai),
        .mi         (mi),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rdata      (mem_rdata)
    );

    // shared bus, one driver picked by the bus-out field
    always_comb begin
        bus = '0;
        if (!eo_n) begin
            case (bus_src)
                SRC_PC:  bus = pc;
                SRC_IRH: bus = {8'hff, ir[7:0]};
                SRC_IRL: bus = {8'h00, ir[7:0]};
                SRC_MEM: bus = mem_rdata;
                SRC_ALU: bus = alu_result;
                SRC_DEV: bus = dev_in_data;
                default: bus = '0;   // spare codes
            endcase
        end
    end

    // device output strobe, one cycle after di
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dev_out_valid <= 1'b0;
        end else begin
            dev_out_valid <= di;
        end
    end

    always_ff @(posedge clk) begin
        if (di) begin
            dev_out_data <= bus;
        end
    end

    assign halted = (ir[15:8] == OP_HALT);

endmodule

//--- test/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// instruction-level model of one program, fills expected with its device-out stream
function automatic void run_model(input int p);
    word_t   mem [MEM_WORDS];
    word_t   x;
    word_t   y;
    word_t   nx;
    logic    z;
    logic    lt;
    logic    done;
    addr_t   pc_m;
    addr_t   arg;
    opcode_t op;
    int      steps;
    int      a;
    for (a = 0; a < MEM_WORDS; a++) begin
        mem[a] = images[p][a];
    end
    x     = '0;
    y     = '0;
    z     = 1'b0;
    lt    = 1'b0;
    done  = 1'b0;
    pc_m  = '0;
    steps = 0;
    expected.delete();
    // forward jumps only, so the step limit is just a backstop
    while (!done && steps < MEM_WORDS) begin
        op    = mem[pc_m][15:8];
        arg   = mem[pc_m][7:0];
        pc_m  = pc_m + 8'd1;
        steps = steps + 1;
        nx    = x;
        case (op)
            OP_LDX_IMM: nx = {8'h00, arg};
            OP_LDY_IMM: y = {8'h00, arg};
            OP_LDX_MEM: nx = mem[arg];
            OP_STX:     mem[arg] = x;
            OP_ADD:     nx = x + y;
            OP_SUB:     nx = x - y;
            OP_AND:     nx = x & y;
            OP_OR:      nx = x | y;
            OP_XOR:     nx = x ^ y;
            OP_OUT:     expected.push_back(x);
            OP_IN:      nx = dev_in[p];
            OP_JMP:     pc_m = arg;
            OP_JZ:      if (z) pc_m = arg;
            OP_JLT:     if (lt) pc_m = arg;
            OP_JGT:     if (!z && !lt) pc_m = arg;
            default:    done = 1'b1;   // halt
        endcase
        // flags follow every write into x
        if (op inside {OP_LDX_IMM, OP_LDX_MEM, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_IN}) begin
            x  = nx;
            z  = (nx == 16'd0);
            lt = nx[15];
        end
    end
endfunction

`endif

//--- test/tb_scamp_cpu.sv
`timescale 1ns/1ps

module tb_scamp_cpu;
    import cpu_types_pkg::*;

    localparam int          NUM_PROGS    = 8;
    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 10;
    localparam int unsigned SEED         = 32'hd04dc682;
    localparam addr_t       DATA_BASE    = 8'hf0;   // scratch words for STX and LDX_MEM

    logic   clk;
    logic   rst_n;
    logic   load_valid;
    addr_t  load_addr;
    word_t  load_data;
    word_t  dev_in_data;
    logic   dev_out_valid;
    word_t  dev_out_data;
    logic   halted;

    word_t  images [NUM_PROGS][MEM_WORDS];
    int     prog_len [NUM_PROGS];
    word_t  dev_in [NUM_PROGS];
    word_t  expected [$];
    int     errors;
    longint limit_ns = 0;

    `include "cpu_model.svh"

    scamp_cpu dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .dev_in_data   (dev_in_data),
        .dev_out_valid (dev_out_valid),
        .dev_out_data  (dev_out_data),
        .halted        (halted)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        int unsigned r;
        r = $urandom();
        return r[7:0];
    endfunction

    // out is weighted up so most paths leave a trace in the stream
    function automatic opcode_t pick_opcode(input int unsigned k);
        case (k)
            0:       return OP_LDX_IMM;
            1:       return OP_LDY_IMM;
            2:       return OP_LDX_MEM;
            3:       return OP_STX;
            4:       return OP_ADD;
            5:       return OP_SUB;
            6:       return OP_AND;
            7:       return OP_OR;
            8:       return OP_XOR;
            9:       return OP_IN;
            10:      return OP_LDY_IMM;
            11:      return OP_SUB;
            12:      return OP_JMP;
            13:      return OP_JZ;
            14:      return OP_JLT;
            15:      return OP_JGT;
            default: return OP_OUT;
        endcase
    endfunction

    task automatic gen_program(input int p);
        int          len;
        int          i;
        int          tgt;
        int unsigned r;
        opcode_t     op;
        addr_t       arg;
        len         = $urandom_range(60, 30);
        prog_len[p] = len;
        dev_in[p]   = {rand_byte(), rand_byte()};
        for (i = 0; i < MEM_WORDS; i++) begin
            images[p][i] = {8'h96 ^ i[7:0], ~i[7:0]};   // fill, also seeds the data words
        end
        for (i = 0; i < len - 1; i++) begin
            op  = pick_opcode($urandom_range(19, 0));
            r   = $urandom();
            arg = r[7:0];
            if (op == OP_STX || op == OP_LDX_MEM) begin
                arg = DATA_BASE | {4'h0, r[3:0]};
            end else if (op inside {OP_JMP, OP_JZ, OP_JLT, OP_JGT}) begin
                tgt = $urandom_range(len - 1, i + 1);   // forward only
                arg = tgt[7:0];
            end
            images[p][i] = {op, arg};
        end
        images[p][len - 1] = {OP_HALT, 8'h00};
    endtask

    task automatic sample_output();
        word_t want;
        if (dev_out_valid) begin
            if (expected.size() == 0) begin
                errors++;
                $display("extra device output %h at %0t ns, nothing more was expected",
                         dev_out_data, $time);
            end else begin
                want = expected.pop_front();
                check_value("dev_out_data", dev_out_data, want);
            end
        end
    endtask

    task automatic run_program(input int p);
        int i;
        @(posedge clk);
        rst_n       <= 1'b0;
        dev_in_data <= dev_in[p];
        run_model(p);
        $display("program %0d: %0d instructions, %0d outputs expected",
                 p, prog_len[p], expected.size());
        // whole image goes in while the CPU is held in reset
        for (i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr  <= i[7:0];
            load_data  <= images[p][i];
        end
        @(posedge clk);
        load_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        do begin
            @(negedge clk);
            sample_output();
        end while (!halted);
        repeat (4) begin
            @(negedge clk);
            sample_output();   // late strobes count as extras
        end
        if (expected.size() != 0) begin
            errors++;
            $display("program %0d halted with %0d expected outputs never seen",
                     p, expected.size());
            expected.delete();
        end
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog expired after %0d ns, the CPU did not reach halt in time", limit_ns);
        $display("test failed");
        $finish;
    end

    initial begin
        int p;
        int total;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        dev_in_data = '0;
        errors      = 0;
        total       = 0;
        for (p = 0; p < NUM_PROGS; p++) begin
            gen_program(p);
            total = total + prog_len[p];
        end
        // at most 4 cycles per instruction, plus loading and reset per program
        limit_ns = longint'(total * 8 + NUM_PROGS * (MEM_WORDS + RESET_CYCLES + 20) + 100)
                   * CLK_PERIOD;
        for (p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("run finished: %0d programs, %0d errors", NUM_PROGS, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+test
logic/cpu_types_pkg.sv
logic/ucode_pkg.sv
logic/ucode_rom.sv
logic/instruction_card.sv
logic/alu_card.sv
logic/memory_card.sv
logic/scamp_cpu.sv
test/tb_scamp_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scamp_cpu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "test failed" $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
